// ==== verilog.f ====
source/rp_pkg.sv
source/rp_adc_format.sv
source/rp_sys_decoder.sv
source/rp_asg_phase.sv
source/rp_asg_gen.sv
source/rp_prop_ctrl.sv
source/rp_dac_sum.sv
source/rp_top.sv
tests/tb_rp_top.sv

// ==== Makefile ====
TOP := tb_rp_top

.PHONY: sim clean

sim:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f verilog.f
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "ALL CHECKS PASSED"

clean:
	rm -rf obj_dir

// ==== tests/tb_rp_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_rp_top;

  localparam int CLK_PERIOD = 4;
  localparam int RST_CYCLES = 10;
  localparam int SMP_RUN    = 200;   // cycles per controller round
  localparam int SMP_SAT    = 50;
  localparam int GEN_RUN    = 300;   // generator cycles before the step freeze
  localparam int N_ACCESS   = 120;   // upper bound of bus accesses, 4 cycles each
  localparam int N_CYCLES   = RST_CYCLES + 4 * N_ACCESS + 3 * SMP_RUN + SMP_SAT + GEN_RUN + 20;
  localparam int TIMEOUT_NS = 2 * N_CYCLES * CLK_PERIOD;

  logic        adc_clk = 1'b0;
  logic        rst_i;
  logic [13:0] adc_dat_a_i, adc_dat_b_i;
  logic [13:0] dac_dat_a_o, dac_dat_b_o;
  logic [31:0] sys_addr_i, sys_wdata_i, sys_rdata_o;
  logic        sys_wen_i, sys_ren_i, sys_ack_o, sys_err_o;

  int          seed = 32'h6f93_896a;
  logic [31:0] rnd;
  int          sp_m [2];        // model setpoints, signed
  int          kp_m [2];        // model gains, signed
  logic [13:0] tbl_m [16];      // model waveform table
  int          wraps_m;         // model carry count

  rp_top u_rp_top (
    .adc_clk     (adc_clk),
    .rst_i       (rst_i),
    .adc_dat_a_i (adc_dat_a_i),
    .adc_dat_b_i (adc_dat_b_i),
    .dac_dat_a_o (dac_dat_a_o),
    .dac_dat_b_o (dac_dat_b_o),
    .sys_addr_i  (sys_addr_i),
    .sys_wdata_i (sys_wdata_i),
    .sys_wen_i   (sys_wen_i),
    .sys_ren_i   (sys_ren_i),
    .sys_rdata_o (sys_rdata_o),
    .sys_ack_o   (sys_ack_o),
    .sys_err_o   (sys_err_o)
  );

  always #(CLK_PERIOD / 2) adc_clk = ~adc_clk;

  // ----------------------------------------
  // reporting
  task automatic abort_run(input string why);
    $display("%s", why);
    $display("CHECKS FAILED");
    $fatal(1, "run stopped");
  endtask

  task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp) begin
      abort_run($sformatf("** Error @ %0t ns: %s, got %0h expected %0h", $time, what, got, exp));
    end
  endtask

  // ----------------------------------------
  // reference model
  function automatic int sext14(input logic [13:0] v);
    int r;
    r = int'(v);
    if (v[13]) r = r - 16384;
    return r;
  endfunction

  function automatic int sext8(input logic [7:0] v);
    int r;
    r = int'(v);
    if (v[7]) r = r - 256;
    return r;
  endfunction

  function automatic int clip14(input int v);
    if (v > 8191) return 8191;
    if (v < -8192) return -8192;
    return v;
  endfunction

  function automatic int conv_sample(input logic [13:0] raw);
    return sext14({raw[13], ~raw[12:0]});          // negative slope front end
  endfunction

  function automatic int p_model(input int sp, input int x, input int kp);
    int prod;
    prod = (sp - x) * kp;
    return clip14(prod >>> 4);                      // floor shift then clip
  endfunction

  function automatic int dac_code(input int asg, input int pid);
    return clip14(asg + pid) + 8192;                // offset binary
  endfunction

  function automatic logic [31:0] mk_addr(input logic [2:0] region, input logic [19:0] ofs);
    return {9'd0, region, ofs};
  endfunction

  function automatic logic [19:0] tbl_ofs(input logic [3:0] idx);
    return rp_pkg::ASG_OFS_TABLE | {14'd0, idx, 2'b00};
  endfunction

  // ----------------------------------------
  // bus access, one idle cycle first so the decoder is back in idle
  task automatic bus_access(input logic wr, input logic [31:0] addr, input logic [31:0] data,
                            output logic [31:0] rdata, output logic err);
    int waited;
    @(posedge adc_clk);
    #1;
    sys_addr_i  = addr;
    sys_wdata_i = data;
    sys_wen_i   = wr;
    sys_ren_i   = ~wr;
    @(posedge adc_clk);
    #1;
    sys_wen_i = 1'b0;
    sys_ren_i = 1'b0;
    waited    = 1;                                   // cycles since the strobe
    while (!sys_ack_o) begin
      if (waited > 8) abort_run("no acknowledge within 8 cycles of the bus strobe");
      @(posedge adc_clk);
      #1;
      waited++;
    end
    check(32'(waited), 32'd2, "ack latency");
    rdata = sys_rdata_o;
    err   = sys_err_o;
  endtask

  task automatic write_reg(input logic [31:0] addr, input logic [31:0] data);
    logic [31:0] rdata;
    logic        err;
    bus_access(1'b1, addr, data, rdata, err);
    check(32'(err), 32'd0, $sformatf("write error flag at %h", addr));
  endtask

  task automatic read_check(input logic [31:0] addr, input logic [31:0] exp,
                            input logic exp_err, input string what);
    logic [31:0] rdata;
    logic        err;
    bus_access(1'b0, addr, 32'd0, rdata, err);
    check(rdata, exp, what);
    check(32'(err), 32'(exp_err), {what, " error flag"});
  endtask

  // setpoint and gain of one channel, written, read back, mirrored in the model
  task automatic set_ctrl(input int ch, input logic [31:0] sp, input logic [31:0] kp);
    logic [19:0] sp_ofs;
    logic [19:0] kp_ofs;
    sp_ofs = (ch == 0) ? rp_pkg::PID_OFS_SP_A : rp_pkg::PID_OFS_SP_B;
    kp_ofs = (ch == 0) ? rp_pkg::PID_OFS_KP_A : rp_pkg::PID_OFS_KP_B;
    write_reg(mk_addr(rp_pkg::REGION_PID, sp_ofs), sp);
    write_reg(mk_addr(rp_pkg::REGION_PID, kp_ofs), kp);
    read_check(mk_addr(rp_pkg::REGION_PID, sp_ofs), sp & 32'h3fff, 1'b0, "setpoint readback");
    read_check(mk_addr(rp_pkg::REGION_PID, kp_ofs), kp & 32'hff, 1'b0, "gain readback");
    sp_m[ch] = sext14(sp[13:0]);
    kp_m[ch] = sext8(kp[7:0]);
  endtask

  // ----------------------------------------
  // controller path, model result due 3 cycles after the sample
  task automatic run_samples(input int n, input logic sat);
    logic [31:0] r;
    int          exp_a[$];
    int          exp_b[$];
    int          ea, eb;
    for (int i = 0; i < n; i++) begin
      if (exp_a.size() == 3) begin
        ea = exp_a.pop_front();
        eb = exp_b.pop_front();
        check(32'(dac_dat_a_o), 32'(ea), "dac a, controller path");
        check(32'(dac_dat_b_o), 32'(eb), "dac b, controller path");
        if (sat) begin
          check(32'(dac_dat_a_o), 32'h3fff, "clip high on a");
          check(32'(dac_dat_b_o), 32'h0000, "clip low on b");
        end
      end
      r = $random(seed);
      adc_dat_a_i = r[13:0];
      adc_dat_b_i = r[29:16];
      if (sat) begin
        adc_dat_a_i[13] = 1'b1;                      // negative sample on a
        adc_dat_b_i[13] = 1'b0;                      // positive sample on b
      end
      exp_a.push_back(dac_code(0, p_model(sp_m[0], conv_sample(adc_dat_a_i), kp_m[0])));
      exp_b.push_back(dac_code(0, p_model(sp_m[1], conv_sample(adc_dat_b_i), kp_m[1])));
      @(posedge adc_clk);
      #1;
    end
  endtask

  // ----------------------------------------
  // generator, entered in the cycle right after the enable write lands
  task automatic run_generator(input int n, input logic [15:0] step);
    int          exp_q[$];
    int          e;
    logic [15:0] phase_m;
    logic [15:0] step_m;
    logic [16:0] sum;
    wraps_m = 0;
    phase_m = 16'd0;
    step_m  = step;
    exp_q.push_back(8192);                           // asg still zero for two cycles
    exp_q.push_back(8192);
    for (int i = 0; i < n + 6; i++) begin
      e = exp_q.pop_front();
      check(32'(dac_dat_a_o), 32'(e), "dac a, generator");
      check(32'(dac_dat_b_o), 32'(e), "dac b, generator");
      exp_q.push_back(dac_code(sext14(tbl_m[phase_m[15:12]]), 0));
      if (i == n + 2) begin
        check(32'(sys_ack_o), 32'd1, "ack of step freeze");
        check(32'(sys_err_o), 32'd0, "error of step freeze");
      end
      if (i >= n + 2) step_m = 16'd0;                // zero step now in the register
      sum = {1'b0, phase_m} + {1'b0, step_m};
      if (sum[16]) wraps_m++;
      phase_m = sum[15:0];
      if (i == n) begin
        sys_addr_i  = mk_addr(rp_pkg::REGION_ASG, rp_pkg::ASG_OFS_STEP);
        sys_wdata_i = 32'd0;
        sys_wen_i   = 1'b1;
      end
      if (i == n + 1) sys_wen_i = 1'b0;
      @(posedge adc_clk);
      #1;
    end
  endtask

  // ----------------------------------------
  // watchdog
  initial begin
    #(TIMEOUT_NS);
    abort_run($sformatf("simulation timed out after %0d ns", TIMEOUT_NS));
  end

  initial begin
    logic [3:0]  idx;
    logic [2:0]  region;
    logic [15:0] step;
    rst_i       = 1'b1;
    adc_dat_a_i = '0;
    adc_dat_b_i = '0;
    sys_addr_i  = '0;
    sys_wdata_i = '0;
    sys_wen_i   = 1'b0;
    sys_ren_i   = 1'b0;
    repeat (RST_CYCLES) @(posedge adc_clk);
    #1;
    rst_i = 1'b0;
    repeat (3) @(posedge adc_clk);
    #1;
    check(32'(sys_ack_o), 32'd0, "ack after reset");
    check(32'(sys_err_o), 32'd0, "err after reset");
    check(32'(dac_dat_a_o), 32'h2000, "dac a after reset");
    check(32'(dac_dat_b_o), 32'h2000, "dac b after reset");

    // register readback
    set_ctrl(0, $random(seed), $random(seed));
    set_ctrl(1, $random(seed), $random(seed));
    rnd = $random(seed);
    write_reg(mk_addr(rp_pkg::REGION_ASG, rp_pkg::ASG_OFS_STEP), rnd);
    read_check(mk_addr(rp_pkg::REGION_ASG, rp_pkg::ASG_OFS_STEP), rnd & 32'hffff, 1'b0,
               "step readback");
    rnd = $random(seed);
    write_reg(mk_addr(rp_pkg::REGION_ASG, rp_pkg::ASG_OFS_EN), rnd);
    read_check(mk_addr(rp_pkg::REGION_ASG, rp_pkg::ASG_OFS_EN), rnd & 32'h1, 1'b0,
               "enable readback");
    for (int i = 0; i < 8; i++) begin
      rnd = $random(seed);
      idx = rnd[23:20];
      write_reg(mk_addr(rp_pkg::REGION_ASG, tbl_ofs(idx)), rnd);
      read_check(mk_addr(rp_pkg::REGION_ASG, tbl_ofs(idx)), rnd & 32'h3fff, 1'b0,
                 "table readback");
    end
    write_reg(mk_addr(rp_pkg::REGION_ASG, rp_pkg::ASG_OFS_EN), 32'd0);

    // unused regions and unmapped offsets
    for (int i = 0; i < 8; i++) begin
      rnd    = $random(seed);
      region = rnd[22:20];
      if (region == rp_pkg::REGION_ASG || region == rp_pkg::REGION_PID) region = region ^ 3'd4;
      read_check(mk_addr(region, rnd[19:0]), 32'd0, 1'b0, "unused region read");
    end
    read_check(mk_addr(rp_pkg::REGION_ASG, 20'h0000c), 32'd0, 1'b1, "asg offset 0x0c");
    read_check(mk_addr(rp_pkg::REGION_ASG, 20'h00010), 32'd0, 1'b1, "asg offset 0x10");
    read_check(mk_addr(rp_pkg::REGION_ASG, 20'h00140), 32'd0, 1'b1, "asg past the table");
    read_check(mk_addr(rp_pkg::REGION_ASG, 20'h00102), 32'd0, 1'b1, "asg unaligned entry");
    read_check(mk_addr(rp_pkg::REGION_PID, 20'h00008), 32'd0, 1'b1, "pid offset 0x08");
    read_check(mk_addr(rp_pkg::REGION_PID, 20'h0000c), 32'd0, 1'b1, "pid offset 0x0c");
    read_check(mk_addr(rp_pkg::REGION_PID, 20'h00018), 32'd0, 1'b1, "pid offset 0x18");
    read_check(mk_addr(rp_pkg::REGION_PID, 20'h00104), 32'd0, 1'b1, "pid offset 0x104");

    // controller path, generator off
    for (int r = 0; r < 3; r++) begin
      set_ctrl(0, $random(seed), $random(seed));
      set_ctrl(1, $random(seed), $random(seed));
      run_samples(SMP_RUN, 1'b0);
    end

    // saturation
    set_ctrl(0, 32'h1fff, 32'h7f);                   // max setpoint, max gain
    set_ctrl(1, 32'h2000, 32'h7f);                   // min setpoint
    run_samples(SMP_SAT, 1'b1);

    // generator, controller gains zero
    set_ctrl(0, $random(seed), 32'd0);
    set_ctrl(1, $random(seed), 32'd0);
    for (int i = 0; i < 16; i++) begin
      rnd      = $random(seed);
      tbl_m[i] = rnd[13:0];
      write_reg(mk_addr(rp_pkg::REGION_ASG, tbl_ofs(4'(i))), rnd);
    end
    rnd  = $random(seed);
    step = rnd[15:0] | 16'h0100;                     // keeps the wraps count busy
    write_reg(mk_addr(rp_pkg::REGION_ASG, rp_pkg::ASG_OFS_STEP), {16'd0, step});
    write_reg(mk_addr(rp_pkg::REGION_ASG, rp_pkg::ASG_OFS_EN), 32'd1);
    run_generator(GEN_RUN, step);
    read_check(mk_addr(rp_pkg::REGION_ASG, rp_pkg::ASG_OFS_WRAPS), 32'(wraps_m), 1'b0,
               "wrap count");
    // still enabled with zero step, count holds its value
    write_reg(mk_addr(rp_pkg::REGION_ASG, rp_pkg::ASG_OFS_WRAPS), 32'h1234);
    read_check(mk_addr(rp_pkg::REGION_ASG, rp_pkg::ASG_OFS_WRAPS), 32'(wraps_m), 1'b0,
               "wraps stays read only");
    write_reg(mk_addr(rp_pkg::REGION_ASG, rp_pkg::ASG_OFS_EN), 32'd0);
    repeat (2) @(posedge adc_clk);
    #1;
    check(32'(dac_dat_a_o), 32'h2000, "dac a after disable");
    check(32'(dac_dat_b_o), 32'h2000, "dac b after disable");

    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== source/rp_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module rp_top (
  input  logic                       adc_clk,
  input  logic                       rst_i,
  input  logic [rp_pkg::ADC_W-1:0]   adc_dat_a_i,  // raw adc ch a
  input  logic [rp_pkg::ADC_W-1:0]   adc_dat_b_i,  // raw adc ch b
  output logic [rp_pkg::ADC_W-1:0]   dac_dat_a_o,
  output logic [rp_pkg::ADC_W-1:0]   dac_dat_b_o,
  input  logic [rp_pkg::BUS_W-1:0]   sys_addr_i,
  input  logic [rp_pkg::BUS_W-1:0]   sys_wdata_i,
  input  logic                       sys_wen_i,
  input  logic                       sys_ren_i,
  output logic [rp_pkg::BUS_W-1:0]   sys_rdata_o,
  output logic                       sys_ack_o,
  output logic                       sys_err_o
);

  logic signed [rp_pkg::ADC_W-1:0] adc_a, adc_b;    // converted samples
  logic signed [rp_pkg::ADC_W-1:0] asg;
  logic signed [rp_pkg::ADC_W-1:0] pid_a, pid_b;
  logic [rp_pkg::BUS_W-1:0]        bus_addr, bus_wdata;
  logic [rp_pkg::BUS_W-1:0]        asg_rdata, pid_rdata;
  logic                            asg_wen, asg_ren, asg_err;
  logic                            pid_wen, pid_ren, pid_err;

  // ----------------------------------------
  // adc front end
  rp_adc_format u_adc_format (
    .adc_clk (adc_clk), .rst_i (rst_i),
    .adc_dat_a_i (adc_dat_a_i), .adc_dat_b_i (adc_dat_b_i),
    .adc_a_o (adc_a), .adc_b_o (adc_b)
  );

  // ----------------------------------------
  // system bus, regions 2 and 3 live
  rp_sys_decoder u_sys_decoder (
    .adc_clk (adc_clk), .rst_i (rst_i),
    .sys_addr_i (sys_addr_i), .sys_wdata_i (sys_wdata_i),
    .sys_wen_i (sys_wen_i), .sys_ren_i (sys_ren_i),
    .asg_rdata_i (asg_rdata), .asg_err_i (asg_err),
    .pid_rdata_i (pid_rdata), .pid_err_i (pid_err),
    .sys_rdata_o (sys_rdata_o), .sys_ack_o (sys_ack_o), .sys_err_o (sys_err_o),
    .bus_addr_o (bus_addr), .bus_wdata_o (bus_wdata),
    .asg_wen_o (asg_wen), .asg_ren_o (asg_ren),
    .pid_wen_o (pid_wen), .pid_ren_o (pid_ren)
  );

  rp_asg_gen u_asg_gen (
    .adc_clk (adc_clk), .rst_i (rst_i),
    .bus_addr_i (bus_addr), .bus_wdata_i (bus_wdata),
    .wen_i (asg_wen), .ren_i (asg_ren),
    .asg_o (asg), .rdata_o (asg_rdata), .err_o (asg_err)
  );

  rp_prop_ctrl u_prop_ctrl (
    .adc_clk (adc_clk), .rst_i (rst_i),
    .adc_a_i (adc_a), .adc_b_i (adc_b),
    .bus_addr_i (bus_addr), .bus_wdata_i (bus_wdata),
    .wen_i (pid_wen), .ren_i (pid_ren),
    .pid_a_o (pid_a), .pid_b_o (pid_b),
    .rdata_o (pid_rdata), .err_o (pid_err)
  );

  // ----------------------------------------
  // dac outputs, one generator feeds both
  rp_dac_sum u_dac_sum_a (
    .adc_clk (adc_clk), .rst_i (rst_i),
    .asg_i (asg), .pid_i (pid_a), .dac_o (dac_dat_a_o)
  );

  rp_dac_sum u_dac_sum_b (
    .adc_clk (adc_clk), .rst_i (rst_i),
    .asg_i (asg), .pid_i (pid_b), .dac_o (dac_dat_b_o)
  );

endmodule

`default_nettype wire

// ==== source/rp_dac_sum.sv ====
`timescale 1ns/1ns
`default_nettype none

module rp_dac_sum (
  input  logic                             adc_clk,
  input  logic                             rst_i,
  input  logic signed [rp_pkg::ADC_W-1:0]  asg_i,
  input  logic signed [rp_pkg::ADC_W-1:0]  pid_i,
  output logic        [rp_pkg::ADC_W-1:0]  dac_o   // offset binary
);

  logic signed [rp_pkg::SUM_W-1:0] sum;
  logic signed [rp_pkg::ADC_W-1:0] sat;

  assign sum = {asg_i[rp_pkg::ADC_W-1], asg_i} + {pid_i[rp_pkg::ADC_W-1], pid_i};

  // top two bits differ -> overflow, clip to +8191 / -8192
  assign sat = (^sum[rp_pkg::SUM_W-1:rp_pkg::SUM_W-2]) ?
               {sum[rp_pkg::SUM_W-1], {(rp_pkg::ADC_W-1){~sum[rp_pkg::SUM_W-1]}}} :
               sum[rp_pkg::ADC_W-1:0];

  // ----------------------------------------
  // two's complement to offset binary
  always_ff @(posedge adc_clk) begin
    if (rst_i) dac_o <= 14'h2000;                   // mid scale
    else       dac_o <= {~sat[rp_pkg::ADC_W-1], sat[rp_pkg::ADC_W-2:0]};
  end

endmodule

`default_nettype wire

// ==== source/rp_prop_ctrl.sv ====
`timescale 1ns/1ns
`default_nettype none

module rp_prop_ctrl (
  input  logic                             adc_clk,
  input  logic                             rst_i,
  input  logic signed [rp_pkg::ADC_W-1:0]  adc_a_i,
  input  logic signed [rp_pkg::ADC_W-1:0]  adc_b_i,
  input  logic        [rp_pkg::BUS_W-1:0]  bus_addr_i,
  input  logic        [rp_pkg::BUS_W-1:0]  bus_wdata_i,
  input  logic                             wen_i,
  input  logic                             ren_i,
  output logic signed [rp_pkg::ADC_W-1:0]  pid_a_o,
  output logic signed [rp_pkg::ADC_W-1:0]  pid_b_o,
  output logic        [rp_pkg::BUS_W-1:0]  rdata_o,
  output logic                             err_o
);

  localparam int PW = rp_pkg::ADC_W + rp_pkg::KP_W + 1;  // product width

  logic [rp_pkg::REGION_LSB-1:0]   ofs;
  logic signed [rp_pkg::ADC_W-1:0] sp_a_q, sp_b_q;       // setpoints
  logic signed [rp_pkg::KP_W-1:0]  kp_a_q, kp_b_q;       // gains
  logic [rp_pkg::BUS_W-1:0]        rd_val;
  logic                            hit;

  // (sp - x) * kp >>> shift, clipped to adc range
  function automatic logic signed [rp_pkg::ADC_W-1:0] p_term(
    input logic signed [rp_pkg::ADC_W-1:0] sp,
    input logic signed [rp_pkg::ADC_W-1:0] smp,
    input logic signed [rp_pkg::KP_W-1:0]  kp
  );
    logic signed [rp_pkg::ADC_W:0]            diff;
    logic signed [PW-1:0]                     prod;
    logic signed [PW-rp_pkg::PID_SHIFT-1:0]   shr;
    diff = sp - smp;                          // one extra bit, no overflow
    prod = diff * kp;
    shr  = prod[PW-1:rp_pkg::PID_SHIFT];      // arithmetic shift right
    if (&shr[PW-rp_pkg::PID_SHIFT-1:rp_pkg::ADC_W-1] ||
        ~|shr[PW-rp_pkg::PID_SHIFT-1:rp_pkg::ADC_W-1])
      return shr[rp_pkg::ADC_W-1:0];          // fits
    return {shr[PW-rp_pkg::PID_SHIFT-1], {(rp_pkg::ADC_W-1){~shr[PW-rp_pkg::PID_SHIFT-1]}}};
  endfunction

  assign ofs = bus_addr_i[rp_pkg::REGION_LSB-1:0];

  // ----------------------------------------
  // registers
  always_ff @(posedge adc_clk) begin
    if (rst_i) begin
      sp_a_q <= '0;
      kp_a_q <= '0;
      sp_b_q <= '0;
      kp_b_q <= '0;
    end else if (wen_i) begin
      if (ofs == rp_pkg::PID_OFS_SP_A) sp_a_q <= bus_wdata_i[rp_pkg::ADC_W-1:0];
      if (ofs == rp_pkg::PID_OFS_KP_A) kp_a_q <= bus_wdata_i[rp_pkg::KP_W-1:0];
      if (ofs == rp_pkg::PID_OFS_SP_B) sp_b_q <= bus_wdata_i[rp_pkg::ADC_W-1:0];
      if (ofs == rp_pkg::PID_OFS_KP_B) kp_b_q <= bus_wdata_i[rp_pkg::KP_W-1:0];
    end
  end

  always_comb begin
    rd_val = '0;
    hit    = 1'b1;
    case (ofs)
      rp_pkg::PID_OFS_SP_A: rd_val = {{(rp_pkg::BUS_W-rp_pkg::ADC_W){1'b0}}, sp_a_q};
      rp_pkg::PID_OFS_KP_A: rd_val = {{(rp_pkg::BUS_W-rp_pkg::KP_W){1'b0}}, kp_a_q};
      rp_pkg::PID_OFS_SP_B: rd_val = {{(rp_pkg::BUS_W-rp_pkg::ADC_W){1'b0}}, sp_b_q};
      rp_pkg::PID_OFS_KP_B: rd_val = {{(rp_pkg::BUS_W-rp_pkg::KP_W){1'b0}}, kp_b_q};
      default:              hit    = 1'b0;  // unmapped offset
    endcase
  end

  always_ff @(posedge adc_clk) begin
    if (rst_i) begin
      rdata_o <= '0;
      err_o   <= 1'b0;
    end else if (wen_i || ren_i) begin
      rdata_o <= ren_i ? rd_val : '0;
      err_o   <= !hit;
    end
  end

  // ----------------------------------------
  // proportional outputs, one cycle
  always_ff @(posedge adc_clk) begin
    if (rst_i) begin
      pid_a_o <= '0;
      pid_b_o <= '0;
    end else begin
      pid_a_o <= p_term(sp_a_q, adc_a_i, kp_a_q);
      pid_b_o <= p_term(sp_b_q, adc_b_i, kp_b_q);
    end
  end

endmodule

`default_nettype wire

// ==== source/rp_asg_gen.sv ====
`timescale 1ns/1ns
`default_nettype none

module rp_asg_gen (
  input  logic                             adc_clk,
  input  logic                             rst_i,
  input  logic        [rp_pkg::BUS_W-1:0]  bus_addr_i,
  input  logic        [rp_pkg::BUS_W-1:0]  bus_wdata_i,
  input  logic                             wen_i,
  input  logic                             ren_i,
  output logic signed [rp_pkg::ADC_W-1:0]  asg_o,
  output logic        [rp_pkg::BUS_W-1:0]  rdata_o,
  output logic                             err_o
);

  logic [rp_pkg::ADC_W-1:0]       tbl [2**rp_pkg::TABLE_AW];  // waveform table
  logic [rp_pkg::TABLE_AW-1:0]    idx;        // bus side index
  logic                           tbl_hit;
  logic [rp_pkg::PHASE_W-1:0]     phase;
  logic                           ph_en;
  logic [rp_pkg::BUS_W-1:0]       ph_rdata;
  logic [rp_pkg::BUS_W-1:0]       tbl_rdata_q;

  rp_asg_phase u_phase (
    .adc_clk     (adc_clk),
    .rst_i       (rst_i),
    .bus_addr_i  (bus_addr_i),
    .bus_wdata_i (bus_wdata_i),
    .wen_i       (wen_i),
    .ren_i       (ren_i),
    .phase_o     (phase),
    .en_o        (ph_en),
    .rdata_o     (ph_rdata),
    .err_o       (err_o)      // phase unit flags anything unmapped
  );

  assign idx     = bus_addr_i[rp_pkg::TABLE_AW+1:2];
  assign tbl_hit = rp_pkg::asg_tbl_hit(bus_addr_i[rp_pkg::REGION_LSB-1:0]);

  // ----------------------------------------
  // table, cleared by reset
  always_ff @(posedge adc_clk) begin
    if (rst_i) begin
      for (int i = 0; i < 2**rp_pkg::TABLE_AW; i++) tbl[i] <= '0;
    end else if (wen_i && tbl_hit) begin
      tbl[idx] <= bus_wdata_i[rp_pkg::ADC_W-1:0];
    end
  end

  // lookup on the top phase bits, zero when stopped
  always_ff @(posedge adc_clk) begin
    if (rst_i) asg_o <= '0;
    else       asg_o <= ph_en ? tbl[phase[rp_pkg::PHASE_W-1 -: rp_pkg::TABLE_AW]] : '0;
  end

  // table read answer, merged with the phase unit
  always_ff @(posedge adc_clk) begin
    if (rst_i) tbl_rdata_q <= '0;
    else if (wen_i || ren_i)
      tbl_rdata_q <= (ren_i && tbl_hit) ?
                     {{(rp_pkg::BUS_W-rp_pkg::ADC_W){1'b0}}, tbl[idx]} : '0;
  end

  assign rdata_o = ph_rdata | tbl_rdata_q;  // only one side is non zero

endmodule

`default_nettype wire

// ==== source/rp_asg_phase.sv ====
`timescale 1ns/1ns
`default_nettype none

module rp_asg_phase (
  input  logic                        adc_clk,
  input  logic                        rst_i,
  input  logic [rp_pkg::BUS_W-1:0]    bus_addr_i,
  input  logic [rp_pkg::BUS_W-1:0]    bus_wdata_i,
  input  logic                        wen_i,
  input  logic                        ren_i,
  output logic [rp_pkg::PHASE_W-1:0]  phase_o,
  output logic                        en_o,     // generator running
  output logic [rp_pkg::BUS_W-1:0]    rdata_o,
  output logic                        err_o
);

  logic [rp_pkg::REGION_LSB-1:0]  ofs;
  logic [rp_pkg::PHASE_W-1:0]     step_q;
  logic [rp_pkg::PHASE_W:0]       phase_sum;  // msb is the carry out
  logic [15:0]                    wraps_q;    // table passes
  logic [rp_pkg::BUS_W-1:0]       rd_val;
  logic                           hit;

  assign ofs = bus_addr_i[rp_pkg::REGION_LSB-1:0];

  // ----------------------------------------
  // control registers
  always_ff @(posedge adc_clk) begin
    if (rst_i) begin
      en_o   <= 1'b0;
      step_q <= '0;
    end else if (wen_i) begin
      if (ofs == rp_pkg::ASG_OFS_EN)   en_o   <= bus_wdata_i[0];
      if (ofs == rp_pkg::ASG_OFS_STEP) step_q <= bus_wdata_i[rp_pkg::PHASE_W-1:0];
    end
  end

  // phase accumulator, held at zero while disabled
  assign phase_sum = {1'b0, phase_o} + {1'b0, step_q};

  always_ff @(posedge adc_clk) begin
    if (rst_i || !en_o) begin
      phase_o <= '0;
      wraps_q <= '0;
    end else begin
      phase_o <= phase_sum[rp_pkg::PHASE_W-1:0];
      wraps_q <= wraps_q + {15'd0, phase_sum[rp_pkg::PHASE_W]};  // count carries
    end
  end

  // ----------------------------------------
  // bus answer, table window answered by the gen
  always_comb begin
    rd_val = '0;
    hit    = 1'b1;
    case (ofs)
      rp_pkg::ASG_OFS_EN:    rd_val = {{(rp_pkg::BUS_W-1){1'b0}}, en_o};
      rp_pkg::ASG_OFS_STEP:  rd_val = {{(rp_pkg::BUS_W-rp_pkg::PHASE_W){1'b0}}, step_q};
      rp_pkg::ASG_OFS_WRAPS: rd_val = {16'd0, wraps_q};
      default:               hit    = rp_pkg::asg_tbl_hit(ofs);
    endcase
  end

  always_ff @(posedge adc_clk) begin
    if (rst_i) begin
      rdata_o <= '0;
      err_o   <= 1'b0;
    end else if (wen_i || ren_i) begin
      rdata_o <= ren_i ? rd_val : '0;
      err_o   <= !hit;  // wraps write just ignored
    end
  end

endmodule

`default_nettype wire

// ==== source/rp_sys_decoder.sv ====
`timescale 1ns/1ns
`default_nettype none

module rp_sys_decoder (
  input  logic                       adc_clk,
  input  logic                       rst_i,
  input  logic [rp_pkg::BUS_W-1:0]   sys_addr_i,
  input  logic [rp_pkg::BUS_W-1:0]   sys_wdata_i,
  input  logic                       sys_wen_i,    // one cycle strobe
  input  logic                       sys_ren_i,    // one cycle strobe
  input  logic [rp_pkg::BUS_W-1:0]   asg_rdata_i,
  input  logic                       asg_err_i,
  input  logic [rp_pkg::BUS_W-1:0]   pid_rdata_i,
  input  logic                       pid_err_i,
  output logic [rp_pkg::BUS_W-1:0]   sys_rdata_o,
  output logic                       sys_ack_o,
  output logic                       sys_err_o,
  output logic [rp_pkg::BUS_W-1:0]   bus_addr_o,   // latched address
  output logic [rp_pkg::BUS_W-1:0]   bus_wdata_o,  // latched write data
  output logic                       asg_wen_o,
  output logic                       asg_ren_o,
  output logic                       pid_wen_o,
  output logic                       pid_ren_o
);

  rp_pkg::bus_state_t           state_q;
  logic                         wr_q;     // access kind, 1 = write
  logic [rp_pkg::REGION_W-1:0]  region;
  logic                         access;

  // ----------------------------------------
  // access FSM, idle -> access -> resp
  always_ff @(posedge adc_clk) begin
    if (rst_i) begin
      state_q <= rp_pkg::IDLE;
      wr_q    <= 1'b0;
    end else begin
      case (state_q)
        rp_pkg::IDLE: if (sys_wen_i || sys_ren_i) begin
          state_q <= rp_pkg::ACCESS;
          wr_q    <= sys_wen_i;
        end
        rp_pkg::ACCESS: state_q <= rp_pkg::RESP;  // slave acts on this edge
        default:        state_q <= rp_pkg::IDLE;  // ack cycle done
      endcase
    end
  end

  // address and data held for the whole access
  always_ff @(posedge adc_clk) begin
    if (state_q == rp_pkg::IDLE && (sys_wen_i || sys_ren_i)) begin
      bus_addr_o  <= sys_addr_i;
      bus_wdata_o <= sys_wdata_i;
    end
  end

  assign region = bus_addr_o[rp_pkg::REGION_LSB +: rp_pkg::REGION_W];
  assign access = (state_q == rp_pkg::ACCESS);

  // slave strobes, none for unused regions
  assign asg_wen_o = access &&  wr_q && (region == rp_pkg::REGION_ASG);
  assign asg_ren_o = access && !wr_q && (region == rp_pkg::REGION_ASG);
  assign pid_wen_o = access &&  wr_q && (region == rp_pkg::REGION_PID);
  assign pid_ren_o = access && !wr_q && (region == rp_pkg::REGION_PID);

  // ----------------------------------------
  // response mux
  assign sys_ack_o = (state_q == rp_pkg::RESP);

  always_comb begin
    sys_rdata_o = '0;     // unused region, zero and no error
    sys_err_o   = 1'b0;
    if (sys_ack_o) begin
      case (region)
        rp_pkg::REGION_ASG: begin
          sys_rdata_o = asg_rdata_i;
          sys_err_o   = asg_err_i;
        end
        rp_pkg::REGION_PID: begin
          sys_rdata_o = pid_rdata_i;
          sys_err_o   = pid_err_i;
        end
        default: ;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== source/rp_adc_format.sv ====
`timescale 1ns/1ns
`default_nettype none

module rp_adc_format (
  input  logic                           adc_clk,
  input  logic                           rst_i,
  input  logic        [rp_pkg::ADC_W-1:0] adc_dat_a_i,  // raw, negative slope
  input  logic        [rp_pkg::ADC_W-1:0] adc_dat_b_i,
  output logic signed [rp_pkg::ADC_W-1:0] adc_a_o,      // two's complement
  output logic signed [rp_pkg::ADC_W-1:0] adc_b_o
);

  // ----------------------------------------
  // front end conversion, one register stage
  // msb kept, remaining bits inverted
  always_ff @(posedge adc_clk) begin
    if (rst_i) begin
      adc_a_o <= '0;
      adc_b_o <= '0;
    end else begin
      adc_a_o <= {adc_dat_a_i[rp_pkg::ADC_W-1], ~adc_dat_a_i[rp_pkg::ADC_W-2:0]};  // ch a
      adc_b_o <= {adc_dat_b_i[rp_pkg::ADC_W-1], ~adc_dat_b_i[rp_pkg::ADC_W-2:0]};  // ch b
    end
  end

endmodule

`default_nettype wire

// ==== source/rp_pkg.sv ====
`default_nettype none

package rp_pkg;

  // ----------------------------------------
  // data path widths
  localparam int ADC_W     = 14;           // adc / dac sample width
  localparam int SUM_W     = ADC_W + 1;    // asg + pid before clipping
  localparam int PHASE_W   = 16;           // generator phase accumulator
  localparam int TABLE_AW  = 4;            // 16 table entries
  localparam int KP_W      = 8;            // signed proportional gain
  localparam int PID_SHIFT = 4;            // scaling after the product

  // ----------------------------------------
  // system bus
  localparam int BUS_W      = 32;
  localparam int REGION_LSB = 20;          // addr[22:20] picks region
  localparam int REGION_W   = 3;
  localparam logic [REGION_W-1:0] REGION_ASG = 3'd2;
  localparam logic [REGION_W-1:0] REGION_PID = 3'd3;

  // generator offsets
  localparam logic [REGION_LSB-1:0] ASG_OFS_EN    = 20'h00000;
  localparam logic [REGION_LSB-1:0] ASG_OFS_STEP  = 20'h00004;
  localparam logic [REGION_LSB-1:0] ASG_OFS_WRAPS = 20'h00008;  // read only
  localparam logic [REGION_LSB-1:0] ASG_OFS_TABLE = 20'h00100;  // + 4*index

  // controller offsets
  localparam logic [REGION_LSB-1:0] PID_OFS_SP_A = 20'h00000;
  localparam logic [REGION_LSB-1:0] PID_OFS_KP_A = 20'h00004;
  localparam logic [REGION_LSB-1:0] PID_OFS_SP_B = 20'h00010;
  localparam logic [REGION_LSB-1:0] PID_OFS_KP_B = 20'h00014;

  typedef enum logic [1:0] {IDLE, ACCESS, RESP} bus_state_t;

  // word aligned offset inside the waveform table window
  function automatic logic asg_tbl_hit(input logic [REGION_LSB-1:0] ofs);
    return (ofs[REGION_LSB-1:TABLE_AW+2] == ASG_OFS_TABLE[REGION_LSB-1:TABLE_AW+2]) &&
           (ofs[1:0] == 2'b00);
  endfunction

endpackage

`default_nettype wire
